// File: verilog/sched_cfg_pkg.sv
package sched_cfg_pkg;

    // fixed port geometry
    localparam int num_ports = 16;  // input queues per egress port
    localparam int cfg_w     = 3;   // config word bits
    localparam int data_w    = 32;  // packet word bits

    // one config word per port
    // sp mode reads it as a priority, wrr mode reads it as a weight
    // 0 masks the port in either mode
    typedef union packed {
        logic [cfg_w-1:0] prio;    // higher wins
        logic [cfg_w-1:0] weight;  // packets per round
    } port_cfg_u;

    // port 0 in the low bits
    typedef port_cfg_u [num_ports-1:0] port_cfg_arr_t;

endpackage

// File: verilog/sched_ctrl_pkg.sv
package sched_ctrl_pkg;

    // index of one of the num_ports queues
    localparam int sel_w = 4;

    // idle waits for a pick, xfer pops the granted queue until eop
    typedef enum logic {
        s_idle = 1'b0,
        s_xfer = 1'b1
    } sched_state_e;

endpackage

// File: verilog/grant_fsm.sv
`timescale 1ns/1ns

module grant_fsm (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                sp0_wrr1,
    input  logic [sched_cfg_pkg::num_ports-1:0] eop,
    input  logic                                pick_valid,
    input  logic [sched_ctrl_pkg::sel_w-1:0]    pick_port,
    output logic [sched_ctrl_pkg::sel_w-1:0]    select,
    output logic [sched_cfg_pkg::num_ports-1:0] next_data,
    output logic                                busy,
    output logic                                grant_stb,
    output logic                                wrr_mode
);

    import sched_cfg_pkg::*;
    import sched_ctrl_pkg::*;

    sched_state_e state;
    sched_state_e state_nxt;

    logic grant;  // pick accepted this cycle
    logic done;   // last word of the granted packet

    // picks are only looked at while idle
    assign grant = (state == s_idle) && pick_valid;
    assign done  = (state == s_xfer) && eop[select];

    always_comb begin
        state_nxt = state;
        case (state)
            s_idle: begin
                if (grant) begin
                    state_nxt = s_xfer;
                end
            end
            s_xfer: begin
                if (done) begin
                    state_nxt = s_idle;  // always one idle cycle after a packet
                end
            end
            default: begin
                state_nxt = s_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // grant side registers
    always_ff @(posedge clk) begin
        if (rst) begin
            select    <= '0;
            next_data <= '0;
            grant_stb <= 1'b0;
            wrr_mode  <= 1'b0;
        end else begin
            grant_stb <= grant;  // first xfer cycle only
            if (grant) begin
                select    <= pick_port;
                next_data <= num_ports'(1) << pick_port;  // one-hot pop level
                wrr_mode  <= sp0_wrr1;  // mode the pick was made in
            end else if (done) begin
                next_data <= '0;  // select holds its value
            end
        end
    end

    assign busy = (state == s_xfer);

endmodule

// File: verilog/port_picker.sv
`timescale 1ns/1ns

module port_picker (
    input  logic                                sp0_wrr1,
    input  logic [sched_cfg_pkg::num_ports-1:0] ready,
    input  sched_cfg_pkg::port_cfg_arr_t        port_cfg,
    input  logic [sched_cfg_pkg::num_ports-1:0] credit_nz,
    input  logic [sched_ctrl_pkg::sel_w-1:0]    rr_ptr,
    output logic                                pick_valid,
    output logic [sched_ctrl_pkg::sel_w-1:0]    pick_port,
    output logic                                pick_reload
);

    import sched_cfg_pkg::*;
    import sched_ctrl_pkg::*;

    logic [cfg_w-1:0]     best_prio;
    logic [sel_w-1:0]     sp_port;
    logic [num_ports-1:0] eligible;    // ready with nonzero weight
    logic [num_ports-1:0] has_credit;
    logic [num_ports-1:0] scan_mask;
    logic                 round_done;  // nobody eligible has credit left
    logic                 wrr_found;
    logic [sel_w-1:0]     wrr_port;
    logic [sel_w-1:0]     idx;

    // strict compare keeps the lowest index on a tie
    always_comb begin
        best_prio = '0;
        sp_port   = '0;
        for (int j = 0; j < num_ports; j++) begin
            if (ready[j] && (port_cfg[j].prio > best_prio)) begin
                best_prio = port_cfg[j].prio;
                sp_port   = sel_w'(j);
            end
        end
    end

    always_comb begin
        for (int j = 0; j < num_ports; j++) begin
            eligible[j] = ready[j] && (port_cfg[j].weight != '0);
        end
    end

    assign has_credit = eligible & credit_nz;
    assign round_done = (has_credit == '0) && (eligible != '0);
    assign scan_mask  = round_done ? eligible : has_credit;  // on reload all weighted ports count

    // rotating search from rr_ptr with the index wrapping at sel_w bits
    always_comb begin
        wrr_found = 1'b0;
        wrr_port  = '0;
        idx       = '0;
        for (int k = 0; k < num_ports; k++) begin
            idx = rr_ptr + sel_w'(k);
            if (!wrr_found && scan_mask[idx]) begin
                wrr_found = 1'b1;
                wrr_port  = idx;
            end
        end
    end

    assign pick_valid  = sp0_wrr1 ? wrr_found : (best_prio != '0);
    assign pick_port   = sp0_wrr1 ? wrr_port : sp_port;
    assign pick_reload = sp0_wrr1 && round_done;

endmodule

// File: verilog/wrr_credit.sv
`timescale 1ns/1ns

module wrr_credit (
    input  logic                                clk,
    input  logic                                rst,
    input  sched_cfg_pkg::port_cfg_arr_t        port_cfg,
    input  logic                                wrr_mode,
    input  logic                                grant_stb,
    input  logic [sched_ctrl_pkg::sel_w-1:0]    select,
    input  logic                                pick_reload,
    output logic [sched_cfg_pkg::num_ports-1:0] credit_nz,
    output logic [sched_ctrl_pkg::sel_w-1:0]    rr_ptr
);

    import sched_cfg_pkg::*;
    import sched_ctrl_pkg::*;

    logic [cfg_w-1:0] credit [num_ports];  // packets left this round
    logic             reload_q;

    // grant_stb comes one cycle after the grant edge, by then the
    // granted queue may have dropped ready, so keep the reload seen at the edge
    always_ff @(posedge clk) begin
        if (rst) begin
            reload_q <= 1'b0;
        end else begin
            reload_q <= pick_reload;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int j = 0; j < num_ports; j++) begin
                credit[j] <= '0;
            end
            rr_ptr <= '0;
        end else if (grant_stb && wrr_mode) begin
            for (int j = 0; j < num_ports; j++) begin
                if (reload_q) begin
                    // the winner already spends one of the new round
                    if (sel_w'(j) == select) begin
                        credit[j] <= port_cfg[j].weight - cfg_w'(1);
                    end else begin
                        credit[j] <= port_cfg[j].weight;
                    end
                end else if ((sel_w'(j) == select) && (credit[j] != '0)) begin
                    credit[j] <= credit[j] - cfg_w'(1);
                end
            end
            rr_ptr <= select + sel_w'(1);  // next search starts past the winner
        end
    end

    always_comb begin
        for (int j = 0; j < num_ports; j++) begin
            credit_nz[j] = |credit[j];
        end
    end

endmodule

// File: verilog/egress_mux.sv
`timescale 1ns/1ns

module egress_mux (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic                                                     busy,
    input  logic [sched_ctrl_pkg::sel_w-1:0]                         select,
    input  logic [sched_cfg_pkg::num_ports-1:0][sched_cfg_pkg::data_w-1:0] data_in,
    input  logic [sched_cfg_pkg::num_ports-1:0]                      eop,
    output logic [sched_cfg_pkg::data_w-1:0]                         out_data,
    output logic                                                     out_valid,
    output logic                                                     out_eop
);

    // qualifiers stay low on idle cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_eop   <= 1'b0;
        end else begin
            out_valid <= busy;
            out_eop   <= busy && eop[select];
        end
    end

    // payload only moves while a packet is in flight
    always_ff @(posedge clk) begin
        if (busy) begin
            out_data <= data_in[select];
        end
    end

endmodule

// File: verilog/out_sched_top.sv
`timescale 1ns/1ns

module out_sched_top (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic                                                     sp0_wrr1,
    input  logic [sched_cfg_pkg::num_ports-1:0]                      ready,
    input  logic [sched_cfg_pkg::num_ports-1:0]                      eop,
    input  logic [sched_cfg_pkg::num_ports-1:0][sched_cfg_pkg::data_w-1:0] data_in,
    input  sched_cfg_pkg::port_cfg_arr_t                             port_cfg,
    output logic [sched_ctrl_pkg::sel_w-1:0]                         select,
    output logic [sched_cfg_pkg::num_ports-1:0]                      next_data,
    output logic                                                     busy,
    output logic [sched_cfg_pkg::data_w-1:0]                         out_data,
    output logic                                                     out_valid,
    output logic                                                     out_eop
);

    import sched_cfg_pkg::*;
    import sched_ctrl_pkg::*;

    logic                 pick_valid;
    logic [sel_w-1:0]     pick_port;
    logic                 pick_reload;
    logic [num_ports-1:0] credit_nz;
    logic [sel_w-1:0]     rr_ptr;
    logic                 grant_stb;
    logic                 wrr_mode;  // mode latched at grant

    port_picker u_picker (
        .sp0_wrr1    (sp0_wrr1),
        .ready       (ready),
        .port_cfg    (port_cfg),
        .credit_nz   (credit_nz),
        .rr_ptr      (rr_ptr),
        .pick_valid  (pick_valid),
        .pick_port   (pick_port),
        .pick_reload (pick_reload)
    );

    grant_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .sp0_wrr1   (sp0_wrr1),
        .eop        (eop),
        .pick_valid (pick_valid),
        .pick_port  (pick_port),
        .select     (select),
        .next_data  (next_data),
        .busy       (busy),
        .grant_stb  (grant_stb),
        .wrr_mode   (wrr_mode)
    );

    wrr_credit u_credit (
        .clk         (clk),
        .rst         (rst),
        .port_cfg    (port_cfg),
        .wrr_mode    (wrr_mode),
        .grant_stb   (grant_stb),
        .select      (select),
        .pick_reload (pick_reload),
        .credit_nz   (credit_nz),
        .rr_ptr      (rr_ptr)
    );

    egress_mux u_egress (
        .clk       (clk),
        .rst       (rst),
        .busy      (busy),
        .select    (select),
        .data_in   (data_in),
        .eop       (eop),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_eop   (out_eop)
    );

endmodule

// File: dv/tb_out_sched.sv
`timescale 1ns/1ns

module tb_out_sched;

    import sched_cfg_pkg::*;
    import sched_ctrl_pkg::*;

    localparam int depth       = 128;  // words per queue model
    localparam int n_rand      = 50;
    localparam int dir_pkts    = 24;   // packets granted by the directed tests
    localparam int dir_words   = 56;
    localparam int idle_cycles = 120;  // reset, quiet windows, test gaps

    logic                             clk;
    logic                             rst;
    logic                             sp0_wrr1;
    logic [num_ports-1:0]             ready;
    logic [num_ports-1:0]             eop;
    logic [num_ports-1:0][data_w-1:0] data_in;
    logic [num_ports*cfg_w-1:0]       port_cfg;
    logic [sel_w-1:0]                 select;
    logic [num_ports-1:0]             next_data;
    logic                             busy;
    logic [data_w-1:0]                out_data;
    logic                             out_valid;
    logic                             out_eop;

    logic [data_w:0]  mem [num_ports][depth];  // {eop, word}
    int               head [num_ports];
    int               tail [num_ports];
    int               chk [num_ports];         // next word the monitor expects
    int               pkt_cnt [num_ports];
    logic [cfg_w-1:0] cfg_val [num_ports];
    logic [cfg_w-1:0] mdl_credit [num_ports];
    int               mdl_ptr;
    int               grant_log [$];
    int               exp_order [$];
    int               pkts_out;
    int               errors;
    int               tests;
    int               fails;
    int               rnd_len [n_rand];
    int               rnd_port [n_rand];
    longint           limit_ns;
    logic             busy_d;
    int               mon_port;
    logic [data_w:0]  mon_word;
    logic [num_ports-1:0] exp_next;

    out_sched_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .sp0_wrr1  (sp0_wrr1),
        .ready     (ready),
        .eop       (eop),
        .data_in   (data_in),
        .port_cfg  (port_cfg),
        .select    (select),
        .next_data (next_data),
        .busy      (busy),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_eop   (out_eop)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // queue models pop the head word on each edge its next_data is high
    always @(posedge clk) begin
        for (int p = 0; p < num_ports; p++) begin
            if (!rst && next_data[p] && (head[p] != tail[p])) begin
                head[p] = head[p] + 1;
            end
            ready[p]   <= (head[p] != tail[p]);
            data_in[p] <= (head[p] != tail[p]) ? mem[p][head[p]][data_w-1:0] : '0;
            eop[p]     <= (head[p] != tail[p]) && mem[p][head[p]][data_w];
        end
    end

    // egress monitor
    always @(posedge clk) begin
        busy_d <= busy;
        if (!rst) begin
            if (busy && !busy_d) begin
                grant_log.push_back(int'(select));
            end
            // pop level of the packet the model expects to be in flight
            exp_next = '0;
            if (busy && grant_log.size() > 0 && grant_log.size() <= exp_order.size()) begin
                exp_next[exp_order[grant_log.size() - 1]] = 1'b1;
            end
            if (next_data != exp_next) begin
                $display("ERROR next_data: got %h expected %h", next_data, exp_next);
                errors++;
            end
            if (out_valid) begin
                if (pkts_out >= grant_log.size()) begin
                    $display("egress word seen with no granted packet");
                    errors++;
                end else begin
                    mon_port = grant_log[pkts_out];
                    mon_word = mem[mon_port][chk[mon_port]];
                    if (out_data != mon_word[data_w-1:0]) begin
                        $display("ERROR out_data: got %h expected %h", out_data,
                                 mon_word[data_w-1:0]);
                        errors++;
                    end
                    if (out_eop != mon_word[data_w]) begin
                        $display("ERROR out_eop: got %h expected %h", out_eop, mon_word[data_w]);
                        errors++;
                    end
                    chk[mon_port] = chk[mon_port] + 1;
                    if (out_eop) begin
                        pkts_out++;
                    end
                end
            end
        end
    end

    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("timeout after %0d ns, the scheduler stopped delivering", limit_ns);
        $display("Finished with errors");
        $finish;
    end

    task automatic drive_cfg(input logic mode);
        @(posedge clk);
        sp0_wrr1 <= mode;
        for (int p = 0; p < num_ports; p++) begin
            port_cfg[p*cfg_w +: cfg_w] <= cfg_val[p];
        end
    endtask

    // call only while idle
    task automatic clear_queues();
        @(negedge clk);
        for (int p = 0; p < num_ports; p++) begin
            head[p]    = 0;
            tail[p]    = 0;
            chk[p]     = 0;
            pkt_cnt[p] = 0;
        end
        grant_log.delete();
        exp_order.delete();
        pkts_out = 0;
    endtask

    task automatic load_packet(input int port, input int len, input logic rnd);
        logic [data_w-1:0] word;
        for (int i = 0; i < len; i++) begin
            word = rnd ? $urandom : {8'(port), 8'(pkt_cnt[port]), 16'(i)};
            mem[port][tail[port]] = {(i == len - 1), word};
            tail[port] = tail[port] + 1;
        end
        pkt_cnt[port] = pkt_cnt[port] + 1;
    endtask

    // grant order from the pick rules with all packets queued up front
    task automatic predict_order(input logic mode);
        int   pend [num_ports];
        int   w;
        int   best;
        int   idx;
        logic any_cred;
        logic done;
        for (int p = 0; p < num_ports; p++) begin
            pend[p] = pkt_cnt[p];
        end
        done = 1'b0;
        while (!done) begin
            w = -1;
            if (!mode) begin
                best = 0;
                for (int p = 0; p < num_ports; p++) begin
                    if (pend[p] > 0 && int'(cfg_val[p]) > best) begin
                        best = int'(cfg_val[p]);
                        w    = p;
                    end
                end
            end else begin
                any_cred = 1'b0;
                for (int p = 0; p < num_ports; p++) begin
                    if (pend[p] > 0 && cfg_val[p] != '0 && mdl_credit[p] != '0) begin
                        any_cred = 1'b1;
                    end
                end
                for (int k = 0; k < num_ports; k++) begin
                    idx = (mdl_ptr + k) % num_ports;
                    if (w < 0 && pend[idx] > 0 && cfg_val[idx] != '0 &&
                        (!any_cred || mdl_credit[idx] != '0)) begin
                        w = idx;
                    end
                end
                if (w >= 0) begin
                    if (!any_cred) begin  // round over
                        for (int p = 0; p < num_ports; p++) begin
                            mdl_credit[p] = cfg_val[p];
                        end
                    end
                    mdl_credit[w] = mdl_credit[w] - 3'd1;
                    mdl_ptr = (w + 1) % num_ports;
                end
            end
            if (w < 0) begin
                done = 1'b1;
            end else begin
                exp_order.push_back(w);
                pend[w]--;
            end
        end
    endtask

    task automatic wait_packets(input int n);
        while (pkts_out < n) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
    endtask

    task automatic check_order(input logic check_drain);
        if (grant_log.size() != exp_order.size()) begin
            $display("granted %0d packets where %0d were expected",
                     grant_log.size(), exp_order.size());
            errors++;
        end
        for (int i = 0; i < grant_log.size() && i < exp_order.size(); i++) begin
            if (grant_log[i] != exp_order[i]) begin
                $display("ERROR select: got %h expected %h", grant_log[i], exp_order[i]);
                errors++;
            end
        end
        for (int p = 0; p < num_ports; p++) begin
            if (check_drain && chk[p] != tail[p]) begin
                $display("port %0d delivered %0d of %0d words", p, chk[p], tail[p]);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors > err_before) begin
            fails++;
            $display("%s: FAIL with %0d errors", name, errors - err_before);
        end else begin
            $display("%s: pass", name);
        end
    endtask

    task automatic quiet_window(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            if (busy || out_valid || out_eop) begin
                $display("ERROR busy/out_valid/out_eop: got %h expected %h",
                         {busy, out_valid, out_eop}, 3'h0);
                errors++;
            end
        end
    endtask

    task automatic idle_after_reset();
        int e0;
        e0 = errors;
        for (int p = 0; p < num_ports; p++) begin
            cfg_val[p] = 3'd1;
        end
        drive_cfg(1'b0);
        clear_queues();
        quiet_window(20);
        report_test("idle after reset", e0);
    endtask

    task automatic strict_priority_order();
        int e0;
        e0 = errors;
        for (int p = 0; p < num_ports; p++) begin
            cfg_val[p] = '0;
        end
        cfg_val[1]  = 3'd3;
        cfg_val[4]  = 3'd5;
        cfg_val[7]  = 3'd3;  // tie with port 1
        cfg_val[9]  = 3'd5;
        cfg_val[12] = 3'd1;
        cfg_val[14] = 3'd7;
        drive_cfg(1'b0);
        clear_queues();
        foreach (cfg_val[p]) begin
            if (cfg_val[p] != '0) begin
                load_packet(p, 3, 1'b0);
            end
        end
        predict_order(1'b0);
        wait_packets(exp_order.size());
        check_order(1'b1);
        report_test("strict priority", e0);
    endtask

    task automatic zero_prio_masking();
        int e0;
        e0 = errors;
        for (int p = 0; p < num_ports; p++) begin
            cfg_val[p] = '0;
        end
        cfg_val[6]  = 3'd4;
        cfg_val[11] = 3'd2;
        drive_cfg(1'b0);
        clear_queues();
        load_packet(0, 3, 1'b0);
        load_packet(3, 3, 1'b0);
        load_packet(6, 3, 1'b0);
        load_packet(10, 3, 1'b0);
        load_packet(11, 3, 1'b0);
        predict_order(1'b0);
        wait_packets(exp_order.size());
        quiet_window(20);  // masked queues still ready
        check_order(1'b0);
        clear_queues();
        report_test("priority 0 masking", e0);
    endtask

    task automatic wrr_grant_order();
        int e0;
        e0 = errors;
        for (int p = 0; p < num_ports; p++) begin
            cfg_val[p] = '0;
        end
        cfg_val[2] = 3'd3;
        cfg_val[5] = 3'd1;
        drive_cfg(1'b1);
        clear_queues();
        for (int i = 0; i < 12; i++) begin
            load_packet(2, 2, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            load_packet(5, 2, 1'b0);
        end
        predict_order(1'b1);
        wait_packets(exp_order.size());
        check_order(1'b1);
        report_test("weighted round robin", e0);
    endtask

    task automatic random_traffic(input logic mode, input int first, input int last);
        int e0;
        e0 = errors;
        for (int p = 0; p < num_ports; p++) begin
            cfg_val[p] = cfg_w'($urandom_range(7, 1));
        end
        drive_cfg(mode);
        clear_queues();
        for (int i = first; i < last; i++) begin
            load_packet(rnd_port[i], rnd_len[i], 1'b1);
        end
        predict_order(mode);
        wait_packets(exp_order.size());
        check_order(1'b1);
        report_test(mode ? "random traffic wrr" : "random traffic sp", e0);
    endtask

    initial begin
        longint budget;
        rst      = 1'b1;
        sp0_wrr1 = 1'b0;
        ready    = '0;
        eop      = '0;
        data_in  = '0;
        port_cfg = '0;
        busy_d   = 1'b0;
        errors   = 0;
        tests    = 0;
        fails    = 0;
        pkts_out = 0;
        mdl_ptr  = 0;
        limit_ns = 0;
        for (int p = 0; p < num_ports; p++) begin
            head[p]       = 0;
            tail[p]       = 0;
            chk[p]        = 0;
            pkt_cnt[p]    = 0;
            cfg_val[p]    = '0;
            mdl_credit[p] = '0;
        end
        void'($urandom(79));
        budget = dir_words + 4 * dir_pkts + idle_cycles;
        for (int i = 0; i < n_rand; i++) begin
            rnd_len[i]  = $urandom_range(8, 1);
            rnd_port[i] = $urandom_range(num_ports - 1, 0);
            budget += rnd_len[i] + 4;
        end
        limit_ns = budget * 20 * 2;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        strict_priority_order();
        zero_prio_masking();
        wrr_grant_order();
        random_traffic(1'b0, 0, 13);
        random_traffic(1'b1, 13, 26);
        random_traffic(1'b0, 26, 38);
        random_traffic(1'b1, 38, n_rand);
        $display("tests %0d, failed %0d, errors %0d", tests, fails, errors);
        if (fails == 0 && errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sim.f
verilog/sched_cfg_pkg.sv
verilog/sched_ctrl_pkg.sv
verilog/grant_fsm.sv
verilog/port_picker.sv
verilog/wrr_credit.sv
verilog/egress_mux.sv
verilog/out_sched_top.sv
dv/tb_out_sched.sv

// File: Makefile
# Verilator build and run of the output scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_out_sched
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run, fails unless the pass message is seen"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
